// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_fpm
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST)) fpm_consts.svh

.PHONY: all lint clean

all: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: fpm_consts.svh
// widths and per-operation shift step counts for the FPU exponent slice, include where needed
`ifndef FPM_CONSTS_SVH
`define FPM_CONSTS_SVH

// exponent byte as it comes off the bus
`define FPM_EXP_W 8

// exponent word, byte plus two guard bits
`define FPM_EXP_FULL_W 10

// shift step counter
`define FPM_FIC_W 6

// loop lengths per operation class

// fixed point multiply
`define FPM_STEPS_MW 16

// fixed point divide
`define FPM_STEPS_DW 32

// floating multiply and divide, full mantissa
`define FPM_STEPS_MF 40
`define FPM_STEPS_DF 40

`endif

// File: fpm_decoder.sv
// instruction decoder of the FPU slice, turns ir and the float-unit select into one-hot classes
`default_nettype none

module fpm_decoder (
	input wire [0:2] ir,
	input wire pufa,
	output logic ad,
	output logic sd,
	output logic mw,
	output logic dw,
	output logic af,
	output logic sf,
	output logic mf,
	output logic df
);

	// one bit per class, index 0 is ad
	logic [0:7] cls;

	always_comb begin
		cls = '0;
		// nothing decodes unless the float unit is selected
		if (pufa) begin
			case (ir)
				3'd0: cls[0] = 1'b1;
				3'd1: cls[1] = 1'b1;
				3'd2: cls[2] = 1'b1;
				3'd3: cls[3] = 1'b1;
				3'd4: cls[4] = 1'b1;
				3'd5: cls[5] = 1'b1;
				3'd6: cls[6] = 1'b1;
				default: cls[7] = 1'b1;
			endcase
		end
	end

	// fixed point add/sub, mul, div
	assign ad = cls[0];
	assign sd = cls[1];
	assign mw = cls[2];
	assign dw = cls[3];

	// floating add/sub, mul, div
	assign af = cls[4];
	assign sf = cls[5];
	assign mf = cls[6];
	assign df = cls[7];

endmodule

`default_nettype wire

// File: fpm_exp_path.sv
// exponent register slice: bus or sum load, previous exponent, operand select and overflow flag
`default_nettype none

`include "fpm_consts.svh"

module fpm_exp_path (
	input wire f2strob,
	input wire _0_d_,
	input wire [0:`FPM_EXP_W-1] w,
	input wire lkb,
	input wire ld,
	input wire fcb,
	input wire scc,
	input wire pc8,
	output fpm_exp_pkg::exp_word_u d,
	output logic g
);

	// previous exponent, taken on every load
	fpm_exp_pkg::exp_word_u dl;

	// operand form of dl fed to the adder
	logic [0:`FPM_EXP_FULL_W-1] opnd;

	// bus byte widened to the full word
	logic [0:`FPM_EXP_FULL_W-1] w_ext;

	fpm_exp_pkg::exp_word_u sum;
	logic sum_ovf;

	assign w_ext = {{(`FPM_EXP_FULL_W-`FPM_EXP_W){w[0]}}, w};

	always_comb begin
		case ({fcb, scc})
			2'b00: opnd = ~dl.val;
			2'b01: opnd = dl.val;
			2'b10: opnd = '1;
			default: opnd = '0;
		endcase
	end

	// carry in from pc8, result wraps at 10 bits
	always_comb begin
		sum.val = opnd + d.val + {{(`FPM_EXP_FULL_W-1){1'b0}}, pc8};
	end

	// result fits a signed byte only if both guard bits copy the byte sign
	assign sum_ovf = (sum.f.guard != {(`FPM_EXP_FULL_W-`FPM_EXP_W){sum.f.exp[0]}});

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			d <= '0;
			dl <= '0;
			g <= 1'b0;
		end else if (ld) begin
			dl <= d;
			if (lkb) begin
				d.val <= w_ext;
				g <= 1'b0;
			end else begin
				d <= sum;
				g <= sum_ovf;
			end
		end
	end

endmodule

`default_nettype wire

// File: fpm_exp_pkg.sv
// exponent word type shared by the exponent path, shift counter and top, referenced by scope
`default_nettype none

`include "fpm_consts.svh"

package fpm_exp_pkg;

	// one exponent word with two readings
	// val is the number the adder works on
	// f splits off the guard bits for the overflow test and the counter load
	typedef union packed {
		logic signed [0:`FPM_EXP_FULL_W-1] val;
		struct packed {
			logic [0:`FPM_EXP_FULL_W-`FPM_EXP_W-1] guard;
			logic [0:`FPM_EXP_W-1] exp;
		} f;
	} exp_word_u;

endpackage

`default_nettype wire

// File: fpm_flags.sv
// condition flag register of the FPU slice, latches C, V, M and Z on the flag strobe
`default_nettype none

module fpm_flags (
	input wire f2strob,
	input wire _0_d_,
	input wire flag_stb,
	input wire g,
	input wire t_zero,
	input wire t_sign,
	input wire t_ovf,
	input wire t_carry,
	input wire ad,
	input wire sd,
	input wire af,
	input wire sf,
	input wire mf,
	input wire df,
	output logic c_f,
	output logic v_f,
	output logic m_f,
	output logic z_f
);

	logic float_op;
	logic v_src;
	logic c_src;

	assign float_op = af | sf | mf | df;

	// float ops report exponent overflow, the rest mantissa overflow
	assign v_src = float_op ? g : t_ovf;

	// carry only means something for fixed add/sub
	assign c_src = (ad | sd) ? t_carry : 1'b0;

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			c_f <= 1'b0;
			v_f <= 1'b0;
			m_f <= 1'b0;
			z_f <= 1'b0;
		end else if (flag_stb) begin
			c_f <= c_src;
			v_f <= v_src;
			m_f <= t_sign;
			z_f <= t_zero;
		end
	end

endmodule

`default_nettype wire

// File: fpm_properties.sv
// bound checker for the FPU exponent slice, concurrent assertions on the fpm_top ports
`default_nettype none

`include "fpm_consts.svh"

module fpm_properties (
	input wire f2strob,
	input wire _0_d_,
	input wire [0:`FPM_EXP_W-1] w,
	input wire lkb, ld, fcb, scc, pc8,
	input wire [0:2] ir,
	input wire pufa, fic_ld, fic_dec, flag_stb,
	input wire t_zero, t_sign, t_ovf, t_carry,
	input wire fpm_exp_pkg::exp_word_u d,
	input wire g,
	input wire ad, sd, mw, dw, af, sf, mf, df,
	input wire [0:`FPM_FIC_W-1] fic,
	input wire fic_z,
	input wire c_f, v_f, m_f, z_f
);

	// read by the testbench after each clock
	int unsigned fail_count = 0;

	// previous exponent as the checker sees it
	logic [0:`FPM_EXP_FULL_W-1] dl_shadow;
	logic [0:`FPM_EXP_FULL_W-1] sum_exp;
	logic ovf_exp;
	logic [0:`FPM_FIC_W-1] fic_exp;
	logic is_float;
	logic is_fixed_add;

	task automatic record_failure(input string what);
		$error("FAILED at %0t: %s", $time, what);
		fail_count++;
	endtask

	// unsigned 10-bit arithmetic, wraps modulo 1024
	function automatic int expected_sum(input logic [0:9] prev, input logic [0:9] cur,
			input logic [0:1] mode, input logic cin);
		int op;
		case (mode)
			2'b00: op = 1023 - int'(prev);
			2'b01: op = int'(prev);
			2'b10: op = 1023;
			default: op = 0;
		endcase
		return (op + int'(cur) + int'(cin)) % 1024;
	endfunction

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			dl_shadow <= '0;
		end else if (ld) begin
			dl_shadow <= d;
		end
	end

	assign sum_exp = 10'(expected_sum(dl_shadow, d, {fcb, scc}, pc8));
	// as a signed word, anything outside -128..127
	assign ovf_exp = (sum_exp >= 10'd128) && (sum_exp < 10'd896);
	assign is_float = pufa && (ir >= 3'd4);
	assign is_fixed_add = pufa && (ir <= 3'd1);

	always_comb begin
		fic_exp = '0;
		if (pufa) begin
			case (ir)
				3'd2: fic_exp = `FPM_FIC_W'(`FPM_STEPS_MW);
				3'd3: fic_exp = `FPM_FIC_W'(`FPM_STEPS_DW);
				3'd4, 3'd5: fic_exp = d.f.exp[2:7];
				3'd6: fic_exp = `FPM_FIC_W'(`FPM_STEPS_MF);
				3'd7: fic_exp = `FPM_FIC_W'(`FPM_STEPS_DF);
				default: fic_exp = '0;
			endcase
		end
	end

	a_reset: assert property (@(posedge f2strob) $rose(_0_d_) |->
		d == '0 && !g && fic == '0 && fic_z && !c_f && !v_f && !m_f && !z_f)
		else record_failure("state not clear after reset");

	a_bus_load: assert property (@(posedge f2strob) disable iff (!_0_d_)
		ld && lkb |=> d == $past({{2{w[0]}}, w}) && !g)
		else record_failure("bus load gave wrong exponent or overflow");

	a_sum: assert property (@(posedge f2strob) disable iff (!_0_d_)
		ld && !lkb |=> d == $past(sum_exp) && g == $past(ovf_exp))
		else record_failure("exponent sum or overflow wrong");

	a_exp_hold: assert property (@(posedge f2strob) disable iff (!_0_d_)
		!ld |=> $stable(d) && $stable(g))
		else record_failure("exponent changed without load");

	a_decode: assert property (@(posedge f2strob) disable iff (!_0_d_)
		{ad, sd, mw, dw, af, sf, mf, df} == (pufa ? (8'h80 >> ir) : 8'h00))
		else record_failure("operation class decode wrong");

	a_fic_load: assert property (@(posedge f2strob) disable iff (!_0_d_)
		fic_ld |=> fic == $past(fic_exp))
		else record_failure("shift counter load value wrong");

	a_fic_dec: assert property (@(posedge f2strob) disable iff (!_0_d_)
		fic_dec && !fic_ld |=>
		(($past(fic) == '0) ? (fic == '0) : (fic == $past(fic) - 6'd1)))
		else record_failure("shift counter decrement wrong");

	a_fic_hold: assert property (@(posedge f2strob) disable iff (!_0_d_)
		!fic_ld && !fic_dec |=> $stable(fic))
		else record_failure("shift counter changed while idle");

	a_fic_z: assert property (@(posedge f2strob) disable iff (!_0_d_)
		fic_z == (fic == '0))
		else record_failure("zero flag does not match count");

	a_flags: assert property (@(posedge f2strob) disable iff (!_0_d_)
		flag_stb |=> z_f == $past(t_zero) && m_f == $past(t_sign) &&
		v_f == $past(is_float ? g : t_ovf) && c_f == $past(is_fixed_add && t_carry))
		else record_failure("condition flags latched wrong source");

	a_flags_hold: assert property (@(posedge f2strob) disable iff (!_0_d_)
		!flag_stb |=> $stable({c_f, v_f, m_f, z_f}))
		else record_failure("condition flags changed without strobe");

endmodule

bind fpm_top fpm_properties u_props (.*);

`default_nettype wire

// File: fpm_shift_ctr.sv
// shift step counter for alignment and mul/div loops, loaded per class and counted down to zero
`default_nettype none

`include "fpm_consts.svh"

module fpm_shift_ctr (
	input wire f2strob,
	input wire _0_d_,
	input wire fpm_exp_pkg::exp_word_u d,
	input wire af,
	input wire sf,
	input wire mw,
	input wire dw,
	input wire mf,
	input wire df,
	input wire fic_ld,
	input wire fic_dec,
	output logic [0:`FPM_FIC_W-1] fic,
	output logic fic_z
);

	logic [0:`FPM_FIC_W-1] load_val;

	always_comb begin
		if (af || sf) begin
			// exponent difference, low bits of the byte
			load_val = d.f.exp[`FPM_EXP_W-`FPM_FIC_W:`FPM_EXP_W-1];
		end else if (mw) begin
			load_val = `FPM_FIC_W'(`FPM_STEPS_MW);
		end else if (dw) begin
			load_val = `FPM_FIC_W'(`FPM_STEPS_DW);
		end else if (mf) begin
			load_val = `FPM_FIC_W'(`FPM_STEPS_MF);
		end else if (df) begin
			load_val = `FPM_FIC_W'(`FPM_STEPS_DF);
		end else begin
			load_val = '0;
		end
	end

	assign fic_z = (fic == '0);

	// load beats decrement, count sticks at zero
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			fic <= '0;
		end else if (fic_ld) begin
			fic <= load_val;
		end else if (fic_dec && !fic_z) begin
			fic <= fic - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: fpm_top.sv
// top of the FPU exponent and control slice, wires the decoder, exponent path, counter and flags
`default_nettype none

`include "fpm_consts.svh"

module fpm_top (
	input wire f2strob,
	input wire _0_d_,
	input wire [0:`FPM_EXP_W-1] w,
	input wire lkb,
	input wire ld,
	input wire fcb,
	input wire scc,
	input wire pc8,
	input wire [0:2] ir,
	input wire pufa,
	input wire fic_ld,
	input wire fic_dec,
	input wire flag_stb,
	input wire t_zero,
	input wire t_sign,
	input wire t_ovf,
	input wire t_carry,
	output wire fpm_exp_pkg::exp_word_u d,
	output wire g,
	output wire ad,
	output wire sd,
	output wire mw,
	output wire dw,
	output wire af,
	output wire sf,
	output wire mf,
	output wire df,
	output wire [0:`FPM_FIC_W-1] fic,
	output wire fic_z,
	output wire c_f,
	output wire v_f,
	output wire m_f,
	output wire z_f
);

	fpm_decoder u_decoder (
		.ir(ir),
		.pufa(pufa),
		.ad(ad),
		.sd(sd),
		.mw(mw),
		.dw(dw),
		.af(af),
		.sf(sf),
		.mf(mf),
		.df(df)
	);

	fpm_exp_path u_exp_path (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.w(w),
		.lkb(lkb),
		.ld(ld),
		.fcb(fcb),
		.scc(scc),
		.pc8(pc8),
		.d(d),
		.g(g)
	);

	fpm_shift_ctr u_shift_ctr (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.d(d),
		.af(af),
		.sf(sf),
		.mw(mw),
		.dw(dw),
		.mf(mf),
		.df(df),
		.fic_ld(fic_ld),
		.fic_dec(fic_dec),
		.fic(fic),
		.fic_z(fic_z)
	);

	fpm_flags u_flags (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.flag_stb(flag_stb),
		.g(g),
		.t_zero(t_zero),
		.t_sign(t_sign),
		.t_ovf(t_ovf),
		.t_carry(t_carry),
		.ad(ad),
		.sd(sd),
		.af(af),
		.sf(sf),
		.mf(mf),
		.df(df),
		.c_f(c_f),
		.v_f(v_f),
		.m_f(m_f),
		.z_f(z_f)
	);

endmodule

`default_nettype wire

// File: tb_fpm.sv
// testbench for the FPU exponent slice, drives fpm_top on falling edges while bound assertions check
`default_nettype none

`include "fpm_consts.svh"

module tb_fpm;

	localparam int directed_cycles = 120;
	localparam int random_cycles = 400;
	// margin covers reset and the drain at the end
	localparam int cycle_limit = directed_cycles + random_cycles + 80;

	logic f2strob = 1'b0;
	logic _0_d_;
	logic [0:`FPM_EXP_W-1] w;
	logic lkb, ld, fcb, scc, pc8;
	logic [0:2] ir;
	logic pufa, fic_ld, fic_dec, flag_stb;
	logic t_zero, t_sign, t_ovf, t_carry;

	wire fpm_exp_pkg::exp_word_u d;
	wire g, ad, sd, mw, dw, af, sf, mf, df;
	wire [0:`FPM_FIC_W-1] fic;
	wire fic_z, c_f, v_f, m_f, z_f;

	logic [31:0] rng_state = 32'h8758;
	int cycle_count = 0;

	fpm_top u_fpm_top (.*);

	always #5 f2strob = ~f2strob;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw(output logic [31:0] r);
		rng_state = lcg_step(rng_state);
		r = rng_state;
	endtask

	// every strobe low, levels keep their values
	task automatic strobes_off();
		ld = 1'b0;
		fic_ld = 1'b0;
		fic_dec = 1'b0;
		flag_stb = 1'b0;
	endtask

	task automatic load_bus(input logic [0:7] b);
		@(negedge f2strob);
		strobes_off();
		w = b;
		lkb = 1'b1;
		ld = 1'b1;
	endtask

	task automatic load_sum(input logic [0:1] mode, input logic cin);
		@(negedge f2strob);
		strobes_off();
		lkb = 1'b0;
		{fcb, scc} = mode;
		pc8 = cin;
		ld = 1'b1;
	endtask

	task automatic class_cycle(input logic [0:2] op, input logic sel, input logic load,
			input logic dec);
		logic [31:0] r;
		@(negedge f2strob);
		strobes_off();
		draw(r);
		ir = op;
		pufa = sel;
		fic_ld = load;
		fic_dec = dec;
		flag_stb = 1'b1;
		{t_zero, t_sign, t_ovf, t_carry} = r[31:28];
	endtask

	task automatic random_cycle();
		logic [31:0] r;
		@(negedge f2strob);
		draw(r);
		w = r[31:24];
		lkb = r[23] & r[22];
		ld = r[21];
		{fcb, scc, pc8} = r[20:18];
		ir = r[17:15];
		pufa = r[14] | r[13];
		fic_ld = r[12] & r[11] & r[10];
		fic_dec = r[9] | r[8];
		flag_stb = r[7];
		{t_zero, t_sign, t_ovf, t_carry} = r[6:3];
	endtask

	always @(posedge f2strob) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("** FAIL **");
			$fatal(1, "timeout, run went past %0d clock cycles", cycle_limit);
		end
	end

	// stop at the first assertion failure
	always @(negedge f2strob) begin
		if (u_fpm_top.u_props.fail_count != 0) begin
			$display("** FAIL **");
			$fatal(1, "bound checker reported an assertion failure");
		end
	end

	initial begin
		logic [31:0] r;
		_0_d_ = 1'b0;
		w = '0;
		{lkb, fcb, scc, pc8} = '0;
		ir = '0;
		pufa = 1'b0;
		{t_zero, t_sign, t_ovf, t_carry} = '0;
		strobes_off();
		repeat (2) @(posedge f2strob);
		@(negedge f2strob);
		_0_d_ = 1'b1;
		// load, load, sum for each operand form and carry
		for (int m = 0; m < 4; m++) begin
			for (int c = 0; c < 2; c++) begin
				draw(r);
				load_bus(r[31:24]);
				load_bus(r[23:16]);
				load_sum(2'(m), 1'(c));
			end
		end
		// dl plus d runs past a signed byte
		load_bus(8'h70);
		load_bus(8'h60);
		load_sum(2'b01, 1'b0);
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < 8; i++) begin
				class_cycle(3'(i), 1'(s), 1'b1, 1'b0);
			end
		end
		// fixed multiply count, run down past zero
		class_cycle(3'd2, 1'b1, 1'b1, 1'b0);
		repeat (`FPM_STEPS_MW + 3) class_cycle(3'd2, 1'b1, 1'b0, 1'b1);
		load_bus(8'he5);
		class_cycle(3'd4, 1'b1, 1'b1, 1'b0);
		class_cycle(3'd5, 1'b1, 1'b1, 1'b1);
		repeat (random_cycles) random_cycle();
		@(negedge f2strob);
		strobes_off();
		repeat (2) @(negedge f2strob);
		if (u_fpm_top.u_props.fail_count != 0) begin
			$display("** FAIL **");
			$fatal(1, "bound checker reported %0d failures", u_fpm_top.u_props.fail_count);
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
fpm_exp_pkg.sv
fpm_decoder.sv
fpm_exp_path.sv
fpm_shift_ctr.sv
fpm_flags.sv
fpm_top.sv
fpm_properties.sv
tb_fpm.sv
